/* hdl/graph_pkg.sv */
package graph_pkg;

    // node name encoding
    localparam int LETTER_WIDTH   = 5;
    localparam int NAME_LETTERS   = 3;
    localparam int NODE_STR_WIDTH = LETTER_WIDTH * NAME_LETTERS;
    localparam int LUT_DEPTH      = 2 ** NODE_STR_WIDTH;

    // index space
    localparam int MAX_NODES      = 1024;
    localparam int NODE_IDX_WIDTH = $clog2(MAX_NODES);

    // edge storage
    localparam int MAX_EDGES       = 2048;
    localparam int EDGE_ADDR_WIDTH = $clog2(MAX_EDGES);

    typedef logic [NODE_STR_WIDTH-1:0]  node_str_t;
    typedef logic [NODE_IDX_WIDTH-1:0]  node_idx_t;
    typedef logic [EDGE_ADDR_WIDTH-1:0] edge_addr_t;
    typedef logic [7:0]                 ascii_t;
    typedef logic [LETTER_WIDTH-1:0]    letter_t;

    // characters of the input grammar
    localparam ascii_t ASCII_A       = 8'h61;
    localparam ascii_t ASCII_Z       = 8'h7a;
    localparam ascii_t ASCII_COLON   = 8'h3a;
    localparam ascii_t ASCII_SPACE   = 8'h20;
    localparam ascii_t ASCII_NEWLINE = 8'h0a;

    // one name-to-index lookup entry
    typedef struct packed {
        logic      assigned;
        node_idx_t node_idx;
    } lut_entry_t;

    // one stored edge
    typedef struct packed {
        node_idx_t src;
        node_idx_t dst;
    } edge_t;

    // first letter sits in the low bits
    // "you" -> y=24, o=14, u=20
    localparam node_str_t START_NODE_STR = {5'd20, 5'd14, 5'd24};
    // "out" -> o=14, u=20, t=19
    localparam node_str_t END_NODE_STR   = {5'd19, 5'd20, 5'd14};

    typedef enum logic [1:0] {
        SRC_NAME,
        COLON_WAIT,
        DST_GAP,
        DST_NAME
    } decode_state_t;

endpackage

/* hdl/node_name_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module node_name_decoder import graph_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      byte_valid,
    input  ascii_t    data_byte,
    input  logic      stream_end,
    output logic      src_node_str_valid,
    output node_str_t src_node_str,
    output logic      edge_str_valid,
    output node_str_t dst_node_str,
    output logic      decoding_done_str
);

    decode_state_t state;
    node_str_t     name_reg;
    logic [1:0]    letter_cnt;
    letter_t       letter_code;
    logic          is_letter;
    logic          is_colon;
    logic          is_space;
    logic          is_newline;
    logic          byte_legal;

    // byte classification
    always_comb begin
        is_letter   = (data_byte >= ASCII_A) && (data_byte <= ASCII_Z);
        is_colon    = (data_byte == ASCII_COLON);
        is_space    = (data_byte == ASCII_SPACE);
        is_newline  = (data_byte == ASCII_NEWLINE);
        letter_code = letter_t'(data_byte - ASCII_A);
    end

    // what the grammar allows in each state
    always_comb begin
        byte_legal = 1'b0;
        unique case (state)
            SRC_NAME:   byte_legal = is_letter;
            COLON_WAIT: byte_legal = is_colon;
            DST_GAP:    byte_legal = is_space;
            DST_NAME: begin
                if (is_letter) begin
                    byte_legal = (letter_cnt != 2'd3);
                end else begin
                    byte_legal = (is_space || is_newline) && (letter_cnt == 2'd3);
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state              <= SRC_NAME;
            letter_cnt         <= '0;
            src_node_str_valid <= 1'b0;
            edge_str_valid     <= 1'b0;
            decoding_done_str  <= 1'b0;
        end else begin
            src_node_str_valid <= 1'b0;
            edge_str_valid     <= 1'b0;
            decoding_done_str  <= stream_end;
            if (byte_valid) begin
                unique case (state)
                    SRC_NAME: begin
                        if (is_letter) begin
                            // third letter completes the source name
                            if (letter_cnt == 2'd2) begin
                                letter_cnt <= '0;
                                state      <= COLON_WAIT;
                            end else begin
                                letter_cnt <= letter_cnt + 2'd1;
                            end
                        end
                    end
                    COLON_WAIT: begin
                        if (is_colon) begin
                            src_node_str_valid <= 1'b1;
                            state              <= DST_GAP;
                        end
                    end
                    DST_GAP: begin
                        if (is_space) begin
                            state <= DST_NAME;
                        end
                    end
                    DST_NAME: begin
                        if (is_letter) begin
                            letter_cnt <= letter_cnt + 2'd1;
                        end else if (is_space || is_newline) begin
                            edge_str_valid <= 1'b1;
                            letter_cnt     <= '0;
                            // end of line, next byte starts a source
                            if (is_newline) begin
                                state <= SRC_NAME;
                            end
                        end
                    end
                endcase
            end
        end
    end

    // shift in from the top so the first letter ends up in the low bits
    always_ff @(posedge clk) begin
        if (byte_valid && is_letter && (state == SRC_NAME || state == DST_NAME)) begin
            name_reg <= {letter_code, name_reg[NODE_STR_WIDTH-1:LETTER_WIDTH]};
        end
    end

    // name holds still for the strobe cycle, the next letter shifts at its end
    assign src_node_str = name_reg;
    assign dst_node_str = name_reg;

    a_byte_in_grammar: assert property (
        @(posedge clk) disable iff (reset) byte_valid |-> byte_legal
    ) else $error("byte 0x%02h does not fit the line grammar", data_byte);

endmodule

`default_nettype wire

/* hdl/node_lut_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module node_lut_ram import graph_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  node_str_t  src_addr,
    input  node_str_t  dst_addr,
    input  logic       src_wr_en,
    input  logic       dst_wr_en,
    input  lut_entry_t src_wr_data,
    input  lut_entry_t dst_wr_data,
    output lut_entry_t src_rd_data,
    output lut_entry_t dst_rd_data
);

    // index storage, never cleared
    node_idx_t            idx_mem [LUT_DEPTH];
    // per-entry assigned bits, cleared by reset
    logic [LUT_DEPTH-1:0] entry_vld;

    node_idx_t src_idx_q;
    node_idx_t dst_idx_q;
    logic      src_vld_q;
    logic      dst_vld_q;

    always_ff @(posedge clk) begin
        if (src_wr_en) begin
            idx_mem[src_addr] <= src_wr_data.node_idx;
        end
        if (dst_wr_en) begin
            idx_mem[dst_addr] <= dst_wr_data.node_idx;
        end
        src_idx_q <= idx_mem[src_addr];
        dst_idx_q <= idx_mem[dst_addr];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            entry_vld <= '0;
            src_vld_q <= 1'b0;
            dst_vld_q <= 1'b0;
        end else begin
            if (src_wr_en) begin
                entry_vld[src_addr] <= src_wr_data.assigned;
            end
            if (dst_wr_en) begin
                entry_vld[dst_addr] <= dst_wr_data.assigned;
            end
            src_vld_q <= entry_vld[src_addr];
            dst_vld_q <= entry_vld[dst_addr];
        end
    end

    assign src_rd_data = '{assigned: src_vld_q, node_idx: src_idx_q};
    assign dst_rd_data = '{assigned: dst_vld_q, node_idx: dst_idx_q};

endmodule

`default_nettype wire

/* hdl/node_id_mapper.sv */
`timescale 1ns/1ps
`default_nettype none

module node_id_mapper import graph_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      decoding_done_str,
    input  logic      src_node_str_valid,
    input  logic      edge_str_valid,
    input  node_str_t src_node_str,
    input  node_str_t dst_node_str,
    output logic      decoding_done_idx,
    output logic      src_node_idx_valid,
    output logic      edge_idx_valid,
    output node_idx_t src_node_idx,
    output node_idx_t dst_node_idx,
    output node_idx_t node_idx_cnt,
    output node_idx_t start_node_idx,
    output node_idx_t end_node_idx,
    output logic      start_end_nodes_valid
);

    // stage 1, lined up with the lut read data
    logic      src_vld_q1;
    logic      dst_vld_q1;
    logic      done_q1;
    node_str_t src_str_q1;
    node_str_t dst_str_q1;

    // lut ports
    node_str_t  src_addr;
    node_str_t  dst_addr;
    logic       src_wr_en;
    logic       dst_wr_en;
    node_str_t  src_wr_str;
    node_str_t  dst_wr_str;
    lut_entry_t src_wr_data;
    lut_entry_t dst_wr_data;
    lut_entry_t src_rd_data;
    lut_entry_t dst_rd_data;

    logic      src_new;
    logic      dst_new;
    node_idx_t src_idx_next;
    node_idx_t dst_idx_next;
    logic      start_found;
    logic      end_found;

    // write-back borrows the address port, the spacing rule keeps it free
    assign src_addr = src_wr_en ? src_wr_str : src_node_str;
    assign dst_addr = dst_wr_en ? dst_wr_str : dst_node_str;

    node_lut_ram node_lut_ram_i (
        .clk         (clk),
        .reset       (reset),
        .src_addr    (src_addr),
        .dst_addr    (dst_addr),
        .src_wr_en   (src_wr_en),
        .dst_wr_en   (dst_wr_en),
        .src_wr_data (src_wr_data),
        .dst_wr_data (dst_wr_data),
        .src_rd_data (src_rd_data),
        .dst_rd_data (dst_rd_data)
    );

    always_ff @(posedge clk) begin
        src_str_q1 <= src_node_str;
        dst_str_q1 <= dst_node_str;
    end

    // unassigned name gets the next free index
    always_comb begin
        src_new      = src_vld_q1 && !src_rd_data.assigned;
        dst_new      = dst_vld_q1 && !dst_rd_data.assigned;
        src_idx_next = src_rd_data.assigned ? src_rd_data.node_idx : node_idx_cnt;
        dst_idx_next = dst_rd_data.assigned ? dst_rd_data.node_idx : node_idx_cnt;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            src_vld_q1            <= 1'b0;
            dst_vld_q1            <= 1'b0;
            done_q1               <= 1'b0;
            src_node_idx_valid    <= 1'b0;
            edge_idx_valid        <= 1'b0;
            decoding_done_idx     <= 1'b0;
            src_wr_en             <= 1'b0;
            dst_wr_en             <= 1'b0;
            node_idx_cnt          <= '0;
            start_found           <= 1'b0;
            end_found             <= 1'b0;
            start_end_nodes_valid <= 1'b0;
        end else begin
            src_vld_q1         <= src_node_str_valid;
            dst_vld_q1         <= edge_str_valid;
            done_q1            <= decoding_done_str;
            src_node_idx_valid <= src_vld_q1;
            edge_idx_valid     <= dst_vld_q1;
            decoding_done_idx  <= done_q1;
            src_wr_en          <= src_new;
            dst_wr_en          <= dst_new;
            // both valids never coincide, so at most one increment
            if (src_new || dst_new) begin
                node_idx_cnt <= node_idx_cnt + 1'b1;
            end
            if (src_vld_q1 && src_str_q1 == START_NODE_STR) begin
                start_found <= 1'b1;
            end
            if (dst_vld_q1 && dst_str_q1 == END_NODE_STR) begin
                end_found <= 1'b1;
            end
            start_end_nodes_valid <= start_found && end_found;
        end
    end

    // payload side of the decision stage
    always_ff @(posedge clk) begin
        src_node_idx <= src_idx_next;
        dst_node_idx <= dst_idx_next;
        src_wr_str   <= src_str_q1;
        dst_wr_str   <= dst_str_q1;
        src_wr_data  <= '{assigned: 1'b1, node_idx: node_idx_cnt};
        dst_wr_data  <= '{assigned: 1'b1, node_idx: node_idx_cnt};
        if (src_vld_q1 && src_str_q1 == START_NODE_STR) begin
            start_node_idx <= src_idx_next;
        end
        if (dst_vld_q1 && dst_str_q1 == END_NODE_STR) begin
            end_node_idx <= dst_idx_next;
        end
    end

    a_valids_exclusive: assert property (
        @(posedge clk) disable iff (reset) !(src_node_str_valid && edge_str_valid)
    ) else $error("source and destination strobes in the same cycle");

    // a strobe must land after the previous write-back
    a_strobe_spacing: assert property (
        @(posedge clk) disable iff (reset)
        (src_node_str_valid || edge_str_valid) |=>
            !(src_node_str_valid || edge_str_valid) [*2]
    ) else $error("node strobes closer than three cycles");

    a_no_index_overflow: assert property (
        @(posedge clk) disable iff (reset)
        (src_new || dst_new) |-> (node_idx_cnt != node_idx_t'(MAX_NODES - 1))
    ) else $error("node index space exhausted");

endmodule

`default_nettype wire

/* hdl/edge_list_store.sv */
`timescale 1ns/1ps
`default_nettype none

module edge_list_store import graph_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       src_node_idx_valid,
    input  logic       edge_idx_valid,
    input  logic       decoding_done_idx,
    input  node_idx_t  src_node_idx,
    input  node_idx_t  dst_node_idx,
    input  edge_addr_t rd_addr,
    output edge_addr_t edge_cnt,
    output edge_t      rd_edge,
    output logic       load_done
);

    edge_t     edge_mem [MAX_EDGES];
    node_idx_t cur_src;
    logic      src_seen;

    // source of the line being loaded
    always_ff @(posedge clk) begin
        if (src_node_idx_valid) begin
            cur_src <= src_node_idx;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            edge_cnt  <= '0;
            src_seen  <= 1'b0;
            load_done <= 1'b0;
        end else begin
            if (src_node_idx_valid) begin
                src_seen <= 1'b1;
            end
            if (edge_idx_valid) begin
                edge_cnt <= edge_cnt + 1'b1;
            end
            // sticky until the next reset
            if (decoding_done_idx) begin
                load_done <= 1'b1;
            end
        end
    end

    // edge ram, one write port and one registered read port
    always_ff @(posedge clk) begin
        if (edge_idx_valid) begin
            edge_mem[edge_cnt] <= '{src: cur_src, dst: dst_node_idx};
        end
        rd_edge <= edge_mem[rd_addr];
    end

    a_edge_after_src: assert property (
        @(posedge clk) disable iff (reset) edge_idx_valid |-> src_seen
    ) else $error("destination index before any source index");

endmodule

`default_nettype wire

/* hdl/graph_loader_top.sv */
`timescale 1ns/1ps
`default_nettype none

module graph_loader_top import graph_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       byte_valid,
    input  ascii_t     data_byte,
    input  logic       stream_end,
    input  edge_addr_t rd_addr,
    output node_idx_t  node_idx_cnt,
    output node_idx_t  start_node_idx,
    output node_idx_t  end_node_idx,
    output logic       start_end_nodes_valid,
    output edge_addr_t edge_cnt,
    output edge_t      rd_edge,
    output logic       load_done
);

    // decoder to mapper
    logic      src_node_str_valid;
    logic      edge_str_valid;
    logic      decoding_done_str;
    node_str_t src_node_str;
    node_str_t dst_node_str;

    // mapper to edge store
    logic      src_node_idx_valid;
    logic      edge_idx_valid;
    logic      decoding_done_idx;
    node_idx_t src_node_idx;
    node_idx_t dst_node_idx;

    node_name_decoder node_name_decoder_i (
        .clk                (clk),
        .reset              (reset),
        .byte_valid         (byte_valid),
        .data_byte          (data_byte),
        .stream_end         (stream_end),
        .src_node_str_valid (src_node_str_valid),
        .src_node_str       (src_node_str),
        .edge_str_valid     (edge_str_valid),
        .dst_node_str       (dst_node_str),
        .decoding_done_str  (decoding_done_str)
    );

    node_id_mapper node_id_mapper_i (
        .clk                   (clk),
        .reset                 (reset),
        .decoding_done_str     (decoding_done_str),
        .src_node_str_valid    (src_node_str_valid),
        .edge_str_valid        (edge_str_valid),
        .src_node_str          (src_node_str),
        .dst_node_str          (dst_node_str),
        .decoding_done_idx     (decoding_done_idx),
        .src_node_idx_valid    (src_node_idx_valid),
        .edge_idx_valid        (edge_idx_valid),
        .src_node_idx          (src_node_idx),
        .dst_node_idx          (dst_node_idx),
        .node_idx_cnt          (node_idx_cnt),
        .start_node_idx        (start_node_idx),
        .end_node_idx          (end_node_idx),
        .start_end_nodes_valid (start_end_nodes_valid)
    );

    edge_list_store edge_list_store_i (
        .clk                (clk),
        .reset              (reset),
        .src_node_idx_valid (src_node_idx_valid),
        .edge_idx_valid     (edge_idx_valid),
        .decoding_done_idx  (decoding_done_idx),
        .src_node_idx       (src_node_idx),
        .dst_node_idx       (dst_node_idx),
        .rd_addr            (rd_addr),
        .edge_cnt           (edge_cnt),
        .rd_edge            (rd_edge),
        .load_done          (load_done)
    );

endmodule

`default_nettype wire

/* tb/graph_loader_tb.sv */
`timescale 1ns/1ps

module graph_loader_tb import graph_pkg::*; ();

    localparam int ROWS = 6;

    // text of each line, and how many names it adds to the index space
    string line_tbl [ROWS] = '{
        "you: abc def\n",
        "abc: def out\n",
        "def: you out ghi\n",
        "ghi: abc\n",
        "out: zed\n",
        "zed: zed you\n"
    };
    int new_name_tbl [ROWS] = '{3, 1, 1, 0, 1, 0};

    logic       clk;
    logic       reset;
    logic       byte_valid;
    ascii_t     data_byte;
    logic       stream_end;
    edge_addr_t rd_addr;
    node_idx_t  node_idx_cnt;
    node_idx_t  start_node_idx;
    node_idx_t  end_node_idx;
    logic       start_end_nodes_valid;
    edge_addr_t edge_cnt;
    edge_t      rd_edge;
    logic       load_done;

    // reference model state
    int        name_idx [string];
    edge_t     exp_edges [$];
    int        exp_node_cnt;
    node_idx_t exp_start;
    node_idx_t exp_end;
    bit        have_start;
    bit        have_end;

    int     total_bytes;
    int     cycle_limit = 0;
    int     cycle_cnt = 0;
    int     pass_start = 0;
    integer seed;

    graph_loader_top dut_i (
        .clk                   (clk),
        .reset                 (reset),
        .byte_valid            (byte_valid),
        .data_byte             (data_byte),
        .stream_end            (stream_end),
        .rd_addr               (rd_addr),
        .node_idx_cnt          (node_idx_cnt),
        .start_node_idx        (start_node_idx),
        .end_node_idx          (end_node_idx),
        .start_end_nodes_valid (start_end_nodes_valid),
        .edge_cnt              (edge_cnt),
        .rd_edge               (rd_edge),
        .load_done             (load_done)
    );

    always #5 clk = ~clk;

    task automatic fail_run(string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1, "stopping at the first error");
    endtask

    // watchdog, per pass
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && (cycle_cnt - pass_start) >= cycle_limit) begin
            fail_run($sformatf("timeout: a pass did not finish within %0d cycles", cycle_limit));
        end
    end

    task automatic check_idx(string name, node_idx_t exp, node_idx_t act);
        if (act !== exp) begin
            fail_run($sformatf("MISMATCH %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_addr(string name, edge_addr_t exp, edge_addr_t act);
        if (act !== exp) begin
            fail_run($sformatf("MISMATCH %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_edge(string name, edge_t exp, edge_t act);
        if (act !== exp) begin
            fail_run($sformatf("MISMATCH %s: expected %0d->%0d, actual %0d->%0d",
                               name, exp.src, exp.dst, act.src, act.dst));
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            fail_run($sformatf("MISMATCH %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // first appearance gets the next index
    function automatic int lookup_index(string name);
        int idx;
        if (!name_idx.exists(name)) begin
            idx = name_idx.num();
            name_idx[name] = idx;
        end
        return name_idx[name];
    endfunction

    task automatic build_model();
        string line;
        string dst_name;
        int    src;
        int    dst;
        int    n_dst;
        edge_t e;
        exp_node_cnt = 0;
        total_bytes  = 0;
        have_start   = 1'b0;
        have_end     = 1'b0;
        for (int r = 0; r < ROWS; r++) begin
            line = line_tbl[r];
            total_bytes  += line.len();
            exp_node_cnt += new_name_tbl[r];
            src = lookup_index(line.substr(0, 2));
            if (line.substr(0, 2) == "you") begin
                exp_start  = node_idx_t'(src);
                have_start = 1'b1;
            end
            // "abc:" then four bytes per destination
            n_dst = (line.len() - 4) / 4;
            for (int j = 0; j < n_dst; j++) begin
                dst_name = line.substr(5 + 4 * j, 7 + 4 * j);
                dst = lookup_index(dst_name);
                if (dst_name == "out") begin
                    exp_end  = node_idx_t'(dst);
                    have_end = 1'b1;
                end
                e.src = node_idx_t'(src);
                e.dst = node_idx_t'(dst);
                exp_edges.push_back(e);
            end
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset = 1'b1;
        repeat (4) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic send_line(string line, bit use_gaps);
        int gap;
        for (int c = 0; c < line.len(); c++) begin
            gap = use_gaps ? ({$random(seed)} % 4) : 0;
            repeat (gap) @(negedge clk);
            byte_valid = 1'b1;
            data_byte  = line.getc(c);
            @(negedge clk);
            byte_valid = 1'b0;
            check_bit("load_done before stream_end", 1'b0, load_done);
        end
    endtask

    task automatic run_pass(string tag, bit use_gaps);
        pass_start = cycle_cnt;
        apply_reset();
        check_bit({tag, " load_done after reset"}, 1'b0, load_done);
        check_bit({tag, " start_end_nodes_valid after reset"}, 1'b0, start_end_nodes_valid);
        check_idx({tag, " node_idx_cnt after reset"}, '0, node_idx_cnt);
        check_addr({tag, " edge_cnt after reset"}, '0, edge_cnt);

        for (int r = 0; r < ROWS; r++) begin
            send_line(line_tbl[r], use_gaps);
        end

        // done travels through decoder, mapper and edge store
        stream_end = 1'b1;
        @(negedge clk);
        stream_end = 1'b0;
        repeat (2) @(negedge clk);
        check_bit({tag, " load_done one cycle early"}, 1'b0, load_done);
        @(negedge clk);
        check_bit({tag, " load_done latency"}, 1'b1, load_done);

        check_idx({tag, " node_idx_cnt"}, node_idx_t'(exp_node_cnt), node_idx_cnt);
        check_addr({tag, " edge_cnt"}, edge_addr_t'(exp_edges.size()), edge_cnt);
        if (have_start && have_end) begin
            check_bit({tag, " start_end_nodes_valid"}, 1'b1, start_end_nodes_valid);
            check_idx({tag, " start_node_idx"}, exp_start, start_node_idx);
            check_idx({tag, " end_node_idx"}, exp_end, end_node_idx);
        end else begin
            check_bit({tag, " start_end_nodes_valid"}, 1'b0, start_end_nodes_valid);
        end

        // registered read port, one cycle per address
        for (int i = 0; i < exp_edges.size(); i++) begin
            rd_addr = edge_addr_t'(i);
            @(negedge clk);
            check_edge($sformatf("%s rd_edge[%0d]", tag, i), exp_edges[i], rd_edge);
        end
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        byte_valid = 1'b0;
        data_byte  = '0;
        stream_end = 1'b0;
        rd_addr    = '0;
        seed       = 32'h50af_2f06;
        build_model();
        cycle_limit = total_bytes * 4 + 100;
        run_pass("back_to_back", 1'b0);
        run_pass("random_gaps", 1'b1);
        $display("test passed");
        $finish;
    end

endmodule

/* compile.f */
hdl/graph_pkg.sv
hdl/node_name_decoder.sv
hdl/node_lut_ram.sv
hdl/node_id_mapper.sv
hdl/edge_list_store.sv
hdl/graph_loader_top.sv
tb/graph_loader_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the graph loader testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module graph_loader_tb \
    -f compile.f -o graph_loader_sim > build.log 2>&1 \
    || { cat build.log; echo "build error"; exit 1; }

./obj_dir/graph_loader_sim > sim.log 2>&1
status=$?
cat sim.log

grep -q "test failed" sim.log && exit 1
[ "$status" -eq 0 ] || exit 1
exit 0
